// ==== src/spm_settings.svh ====
// SPM subsystem settings
// Global widths and sizes shared by the scratchpad, the mapper and the response merge

`ifndef SPM_SETTINGS_SVH
`define SPM_SETTINGS_SVH

// Full core address width
`define ADDR_W 32

// Byte address width of the scratchpad, 1 KiB
`define SPM_ADDR_W 10

// Data bus width
`define DATA_W 32

// Number of words in the SPM bank
`define SPM_WORDS 256

// Default depth of the merged response FIFO
`define RSP_FIFO_DEPTH 4

`endif

// ==== src/spm_pkg.sv ====
// SPM subsystem package
// Vector types for addresses, data and strobes, plus the arbiter priority state

`include "spm_settings.svh"

package spm_pkg;

  // Full address as seen by the core and the cache
  typedef logic [`ADDR_W-1:0] addr_t;

  // Truncated address inside the scratchpad
  typedef logic [`SPM_ADDR_W-1:0] spm_addr_t;

  // Data word and its byte enables
  typedef logic [`DATA_W-1:0] data_t;
  typedef logic [`DATA_W/8-1:0] strb_t;

  // Source favoured by the response arbiter on a tie
  typedef enum logic {
    PRIO_SPM   = 1'b0,
    PRIO_CACHE = 1'b1
  } rr_prio_e;

endpackage

// ==== src/mem_req_if.sv ====
// Memory request channel
// Valid/ready request bus with address, write flag, write data and byte strobes

`timescale 1ns/1ps

`include "spm_settings.svh"

interface mem_req_if #(
  // Full or truncated address, depending on the target
  parameter type addr_t = spm_pkg::addr_t
);

  logic            valid;
  logic            ready;
  addr_t           addr;
  logic            write;
  spm_pkg::data_t  wdata;
  spm_pkg::strb_t  strb;

  // Requester side, holds valid and payload until ready
  modport master (output valid, addr, write, wdata, strb, input ready);

  // Target side
  modport slave (input valid, addr, write, wdata, strb, output ready);

endinterface

// ==== src/spm_addr_mapper.sv ====
// SPM address mapper
// Steers each core request to the scratchpad or the cache using the TCDM window,
// flags accesses that fall past the populated scratchpad and drops them

`timescale 1ns/1ps

`include "spm_settings.svh"

module spm_addr_mapper (
  mem_req_if.slave         core,
  mem_req_if.master        spm,

  // Window configuration
  input  spm_pkg::addr_t   tcdm_start_addr_i,
  input  spm_pkg::addr_t   tcdm_end_addr_i,
  input  spm_pkg::addr_t   spm_size_i,

  // Cache request port, full address
  output logic             cache_req_valid_o,
  input  logic             cache_req_ready_i,
  output spm_pkg::addr_t   cache_req_addr_o,
  output logic             cache_req_write_o,
  output spm_pkg::data_t   cache_req_wdata_o,
  output spm_pkg::strb_t   cache_req_strb_o,

  output logic             error_o
);

  // --------------------
  // Target decode
  // --------------------
  spm_pkg::addr_t spm_end_addr;
  logic           in_window;
  logic           in_spm;
  logic           out_of_range;

  // End of the populated part of the window
  assign spm_end_addr = tcdm_start_addr_i + spm_size_i;

  assign in_window    = (core.addr >= tcdm_start_addr_i) && (core.addr < tcdm_end_addr_i);
  assign in_spm       = in_window && (core.addr < spm_end_addr);
  // Inside the window but at or past start plus size
  assign out_of_range = in_window && !in_spm;

  // --------------------
  // Request forwarding
  // --------------------
  // Payload goes to both sides, only one valid is raised
  assign spm.valid  = core.valid && in_spm;
  assign spm.addr   = core.addr[`SPM_ADDR_W-1:0];
  assign spm.write  = core.write;
  assign spm.wdata  = core.wdata;
  assign spm.strb   = core.strb;

  assign cache_req_valid_o = core.valid && !in_window;
  assign cache_req_addr_o  = core.addr;
  assign cache_req_write_o = core.write;
  assign cache_req_wdata_o = core.wdata;
  assign cache_req_strb_o  = core.strb;

  // Error only while a request is actually presented
  assign error_o = core.valid && out_of_range;

  // Handshake back to the core follows the request target
  always_comb begin
    if (out_of_range) begin
      // Acknowledge and drop, no response follows
      core.ready = 1'b1;
    end else if (in_spm) begin
      core.ready = spm.ready;
    end else begin
      core.ready = cache_req_ready_i;
    end
  end

endmodule

// ==== src/spm_bank.sv ====
// SPM bank
// Single-cycle scratchpad RAM with byte strobes and one held response register

`timescale 1ns/1ps

`include "spm_settings.svh"

module spm_bank (
  input  logic            clk_i,
  input  logic            arst_n_i,
  mem_req_if.slave        req,
  output logic            rsp_valid_o,
  input  logic            rsp_ready_i,
  output spm_pkg::data_t  rsp_data_o
);

  localparam int unsigned NUM_BYTES = `DATA_W / 8;
  localparam int unsigned WORD_LSB  = $clog2(NUM_BYTES);
  localparam int unsigned IDX_W     = $clog2(`SPM_WORDS);

  spm_pkg::data_t   mem_q [`SPM_WORDS];
  spm_pkg::data_t   rsp_data_q;
  logic             rsp_valid_q;
  logic [IDX_W-1:0] word_idx;
  logic             req_fire;

  // Word select from the byte address
  assign word_idx = req.addr[WORD_LSB +: IDX_W];

  // Accept when the response slot is free or drains this cycle
  assign req.ready = !rsp_valid_q || rsp_ready_i;
  assign req_fire  = req.valid && req.ready;

  // --------------------
  // Response valid
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Storage and response data, writes answer with zero
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (req.write) begin
        for (int b = 0; b < NUM_BYTES; b++) begin
          if (req.strb[b]) begin
            mem_q[word_idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
          end
        end
        rsp_data_q <= '0;
      end else begin
        rsp_data_q <= mem_q[word_idx];
      end
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_data_o  = rsp_data_q;

endmodule

// ==== src/spm_rsp_merge.sv ====
// SPM response merge
// Round-robin arbiter with lock-in between the scratchpad and cache responses,
// feeding a registered response FIFO towards the core

`timescale 1ns/1ps

`include "spm_settings.svh"

module spm_rsp_merge #(
  parameter int unsigned DEPTH = `RSP_FIFO_DEPTH
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            spm_valid_i,
  output logic            spm_ready_o,
  input  spm_pkg::data_t  spm_data_i,
  input  logic            cache_valid_i,
  output logic            cache_ready_o,
  input  spm_pkg::data_t  cache_data_i,
  output logic            rsp_valid_o,
  input  logic            rsp_ready_i,
  output spm_pkg::data_t  rsp_data_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  spm_pkg::rr_prio_e prio_q;
  spm_pkg::rr_prio_e lock_src_q;
  spm_pkg::rr_prio_e gnt_src;
  logic              lock_q;
  logic              gnt_valid;
  logic              full;
  logic              push;
  logic              pop;
  spm_pkg::data_t    push_data;
  spm_pkg::data_t    fifo_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;

  // --------------------
  // Arbiter
  // --------------------
  always_comb begin
    gnt_valid = 1'b0;
    gnt_src   = prio_q;
    if (lock_q) begin
      // Stay on a grant that has not transferred yet
      gnt_valid = 1'b1;
      gnt_src   = lock_src_q;
    end else if (spm_valid_i && cache_valid_i) begin
      gnt_valid = 1'b1;
      gnt_src   = prio_q;
    end else if (spm_valid_i) begin
      gnt_valid = 1'b1;
      gnt_src   = spm_pkg::PRIO_SPM;
    end else if (cache_valid_i) begin
      gnt_valid = 1'b1;
      gnt_src   = spm_pkg::PRIO_CACHE;
    end
  end

  assign full          = (count_q == FULL_CNT);
  assign push          = gnt_valid && !full;
  assign pop           = rsp_valid_o && rsp_ready_i;
  assign spm_ready_o   = gnt_valid && (gnt_src == spm_pkg::PRIO_SPM) && !full;
  assign cache_ready_o = gnt_valid && (gnt_src == spm_pkg::PRIO_CACHE) && !full;
  assign push_data     = (gnt_src == spm_pkg::PRIO_SPM) ? spm_data_i : cache_data_i;

  // Priority flips after every transfer, lock holds a stalled grant
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q     <= spm_pkg::PRIO_SPM;
      lock_q     <= 1'b0;
      lock_src_q <= spm_pkg::PRIO_SPM;
    end else if (push) begin
      prio_q <= (gnt_src == spm_pkg::PRIO_SPM) ? spm_pkg::PRIO_CACHE : spm_pkg::PRIO_SPM;
      lock_q <= 1'b0;
    end else if (gnt_valid) begin
      lock_q     <= 1'b1;
      lock_src_q <= gnt_src;
    end
  end

  // --------------------
  // Response FIFO
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= push_data;
    end
  end

  // Head entry, visible the cycle after its push
  assign rsp_valid_o = (count_q != '0);
  assign rsp_data_o  = fifo_q[rd_ptr_q];

endmodule

// ==== src/spm_subsystem_top.sv ====
// SPM subsystem top
// Core memory port split between an internal scratchpad and an external cache,
// with both response paths merged back towards the core

`timescale 1ns/1ps

`include "spm_settings.svh"

module spm_subsystem_top (
  input  logic            clk_i,
  input  logic            arst_n_i,

  // Core request and response
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  spm_pkg::addr_t  req_addr_i,
  input  logic            req_write_i,
  input  spm_pkg::data_t  req_wdata_i,
  input  spm_pkg::strb_t  req_strb_i,
  output logic            rsp_valid_o,
  input  logic            rsp_ready_i,
  output spm_pkg::data_t  rsp_data_o,
  output logic            error_o,

  // Window configuration
  input  spm_pkg::addr_t  tcdm_start_addr_i,
  input  spm_pkg::addr_t  tcdm_end_addr_i,
  input  spm_pkg::addr_t  spm_size_i,

  // External cache
  output logic            cache_req_valid_o,
  input  logic            cache_req_ready_i,
  output spm_pkg::addr_t  cache_req_addr_o,
  output logic            cache_req_write_o,
  output spm_pkg::data_t  cache_req_wdata_o,
  output spm_pkg::strb_t  cache_req_strb_o,
  input  logic            cache_rsp_valid_i,
  output logic            cache_rsp_ready_o,
  input  spm_pkg::data_t  cache_rsp_data_i
);

  mem_req_if #(.addr_t(spm_pkg::addr_t))     core_req ();
  mem_req_if #(.addr_t(spm_pkg::spm_addr_t)) spm_req ();

  logic           spm_rsp_valid;
  logic           spm_rsp_ready;
  spm_pkg::data_t spm_rsp_data;

  // Core port into the request bus
  assign core_req.valid = req_valid_i;
  assign core_req.addr  = req_addr_i;
  assign core_req.write = req_write_i;
  assign core_req.wdata = req_wdata_i;
  assign core_req.strb  = req_strb_i;
  assign req_ready_o    = core_req.ready;

  spm_addr_mapper u_mapper (
    .core              (core_req),
    .spm               (spm_req),
    .tcdm_start_addr_i (tcdm_start_addr_i),
    .tcdm_end_addr_i   (tcdm_end_addr_i),
    .spm_size_i        (spm_size_i),
    .cache_req_valid_o (cache_req_valid_o),
    .cache_req_ready_i (cache_req_ready_i),
    .cache_req_addr_o  (cache_req_addr_o),
    .cache_req_write_o (cache_req_write_o),
    .cache_req_wdata_o (cache_req_wdata_o),
    .cache_req_strb_o  (cache_req_strb_o),
    .error_o           (error_o)
  );

  spm_bank u_bank (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req         (spm_req),
    .rsp_valid_o (spm_rsp_valid),
    .rsp_ready_i (spm_rsp_ready),
    .rsp_data_o  (spm_rsp_data)
  );

  // Both response sources share one FIFO to the core
  spm_rsp_merge #(.DEPTH(`RSP_FIFO_DEPTH)) u_merge (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .spm_valid_i   (spm_rsp_valid),
    .spm_ready_o   (spm_rsp_ready),
    .spm_data_i    (spm_rsp_data),
    .cache_valid_i (cache_rsp_valid_i),
    .cache_ready_o (cache_rsp_ready_o),
    .cache_data_i  (cache_rsp_data_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_data_o    (rsp_data_o)
  );

endmodule

// ==== tests/spm_tb_clock.sv ====
// Testbench clock and reset
// Free-running clock and an active-low reset held for a fixed number of cycles

`timescale 1ns/1ps

module spm_tb_clock #(
  parameter real PERIOD_NS  = 4.0,
  parameter int  RST_CYCLES = 4
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // Release away from the clock edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    arst_n_o = 1'b1;
  end

endmodule

// ==== tests/spm_subsystem_asserts.sv ====
// SPM subsystem protocol assertions
// Watches the core request and response handshakes of the top level

`timescale 1ns/1ps

module spm_subsystem_asserts (
  input logic           clk_i,
  input logic           arst_n_i,
  input logic           req_valid_i,
  input logic           req_ready_i,
  input logic           rsp_valid_i,
  input logic           rsp_ready_i,
  input spm_pkg::data_t rsp_data_i,
  input logic           error_i
);

  // Number of assertion failures so far
  int unsigned failures = 0;

  // Response FIFO leaves reset empty
  rsp_idle_after_reset: assert property (@(posedge clk_i) $rose(arst_n_i) |-> !rsp_valid_i)
    else begin
      failures++;
      $error("rsp_valid_o high in the first cycle after reset");
    end

  // Stalled response holds valid and data
  rsp_stable_on_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_data_i))
    else begin
      failures++;
      $error("rsp_valid_o or rsp_data_o changed while rsp_ready_i was low");
    end

  // Error flag only with a request present
  error_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    error_i |-> req_valid_i)
    else begin
      failures++;
      $error("error_o high without req_valid_i");
    end

  // Request stays up until accepted
  req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i && !req_ready_i |=> req_valid_i)
    else begin
      failures++;
      $error("req_valid_i dropped before req_ready_o");
    end

endmodule

// ==== tests/spm_subsystem_tb.sv ====
// SPM subsystem testbench
// Random SPM, cache and error traffic, checked against a byte model of the
// scratchpad and a cache responder that lives in the testbench

`timescale 1ns/1ps

`include "spm_settings.svh"

module spm_subsystem_tb;

  localparam spm_pkg::addr_t WIN_START = 32'h1000_0000;
  localparam spm_pkg::addr_t WIN_END   = 32'h1000_1000;
  localparam spm_pkg::addr_t SPM_SIZE  = 32'h0000_0400;
  localparam spm_pkg::data_t CACHE_KEY = 32'hA5A5_A5A5;
  localparam spm_pkg::data_t FILL_KEY  = 32'h3C5A_0FF0;
  localparam int unsigned    SEED      = 32'h6e977e84;
  localparam int NB      = `DATA_W / 8;
  localparam int N_SPM   = 200;
  localparam int N_CACHE = 100;
  localparam int N_ERR   = 20;
  localparam int N_MIX   = 200;
  // About 5000 cycles of traffic even with cache and response stalls, plus margin
  localparam int MAX_CYCLES = 20000;
  localparam int ROUTE_SPM   = 0;
  localparam int ROUTE_ERR   = 1;
  localparam int ROUTE_CACHE = 2;

  logic clk;
  logic arst_n;
  logic req_valid, req_ready, req_write, req_error;
  logic rsp_valid, rsp_ready;
  logic cache_req_valid, cache_req_ready, cache_req_write;
  logic cache_rsp_valid, cache_rsp_ready;
  spm_pkg::addr_t req_addr, cache_req_addr;
  spm_pkg::data_t req_wdata, rsp_data, cache_req_wdata, cache_rsp_data;
  spm_pkg::strb_t req_strb, cache_req_strb;

  // Byte model of the scratchpad and the queue of expected responses
  logic [7:0]     spm_bytes [1 << `SPM_ADDR_W];
  spm_pkg::data_t exp_q [$];
  int  checks = 0;
  int  errors = 0;
  int  rsp_count = 0;
  int  cycle = 0;
  int  hs_cycle = 0;
  int  rsp_cycle = 0;
  bit  set_match = 1'b0;
  bit  backpressure = 1'b0;

  spm_tb_clock #(.PERIOD_NS(4.0), .RST_CYCLES(4)) u_clock (.clk_o(clk), .arst_n_o(arst_n));

  spm_subsystem_top u_spm_subsystem_top (
    .clk_i (clk), .arst_n_i (arst_n),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_addr_i (req_addr),
    .req_write_i (req_write), .req_wdata_i (req_wdata), .req_strb_i (req_strb),
    .rsp_valid_o (rsp_valid), .rsp_ready_i (rsp_ready), .rsp_data_o (rsp_data),
    .error_o (req_error),
    .tcdm_start_addr_i (WIN_START), .tcdm_end_addr_i (WIN_END), .spm_size_i (SPM_SIZE),
    .cache_req_valid_o (cache_req_valid), .cache_req_ready_i (cache_req_ready),
    .cache_req_addr_o (cache_req_addr), .cache_req_write_o (cache_req_write),
    .cache_req_wdata_o (cache_req_wdata), .cache_req_strb_o (cache_req_strb),
    .cache_rsp_valid_i (cache_rsp_valid), .cache_rsp_ready_o (cache_rsp_ready),
    .cache_rsp_data_i (cache_rsp_data)
  );

  bind spm_subsystem_top spm_subsystem_asserts u_asserts (
    .clk_i (clk_i), .arst_n_i (arst_n_i), .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_o), .rsp_valid_i (rsp_valid_o), .rsp_ready_i (rsp_ready_i),
    .rsp_data_i (rsp_data_o), .error_i (error_o)
  );

  // --------------------
  // Model and checks
  // --------------------
  // Window rule, start inclusive and end exclusive
  function automatic int route_of(spm_pkg::addr_t a);
    if (a >= WIN_START && a < WIN_END) begin
      return (a < WIN_START + SPM_SIZE) ? ROUTE_SPM : ROUTE_ERR;
    end
    return ROUTE_CACHE;
  endfunction

  function automatic spm_pkg::data_t model_read(int unsigned off);
    spm_pkg::data_t w;
    for (int b = 0; b < NB; b++) begin
      w[b*8 +: 8] = spm_bytes[off + b];
    end
    return w;
  endfunction

  function automatic spm_pkg::addr_t random_cache_addr();
    spm_pkg::addr_t a;
    do a = $urandom; while (route_of(a) != ROUTE_CACHE);
    return a;
  endfunction

  task automatic compare_data(string what, spm_pkg::data_t got, spm_pkg::data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic expect_true(logic cond, string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("Fail at %0t ns: %s", $time, what);
    end
  endtask

  // Present one request, record its expected response at the handshake
  task automatic issue_req(spm_pkg::addr_t addr, logic write, spm_pkg::data_t wdata,
                           spm_pkg::strb_t strb);
    int          route;
    int unsigned off;
    route = route_of(addr);
    off   = int'(addr - WIN_START);
    req_valid = 1'b1;
    req_addr  = addr;
    req_write = write;
    req_wdata = wdata;
    req_strb  = strb;
    do @(negedge clk); while (!req_ready);
    hs_cycle = cycle;
    if (route == ROUTE_SPM) begin
      expect_true(!cache_req_valid && !req_error, "SPM request leaked to cache or error_o");
      if (write) begin
        for (int b = 0; b < NB; b++) begin
          if (strb[b]) spm_bytes[off + b] = wdata[b*8 +: 8];
        end
        exp_q.push_back('0);
      end else begin
        exp_q.push_back(model_read(off));
      end
    end else if (route == ROUTE_ERR) begin
      expect_true(req_error, "error_o low for an address past the populated SPM");
      expect_true(!cache_req_valid && !u_spm_subsystem_top.spm_req.valid,
                  "error request reached the SPM or the cache");
    end else begin
      expect_true(cache_req_valid && !req_error, "cache request not routed to the cache");
      compare_data("cache address", cache_req_addr, addr);
      compare_data("cache write data", cache_req_wdata, wdata);
      expect_true(cache_req_write == write && cache_req_strb == strb,
                  "cache write flag or strobes changed");
      exp_q.push_back(write ? '0 : addr ^ CACHE_KEY);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) @(negedge clk);
    repeat (4) @(posedge clk);
    #1;
  endtask

  task automatic report_test(int num, string name, int c0, int e0);
    $display("Test %0d (%s) done: %0d checks, %0d errors", num, name, checks - c0, errors - e0);
  endtask

  // --------------------
  // Environment processes
  // --------------------
  // Response checker, in order or as a multiset
  initial begin : collect_rsp
    int hits [$];
    forever begin
      @(negedge clk);
      if (rsp_valid && rsp_ready) begin
        rsp_cycle = cycle;
        rsp_count++;
        checks++;
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("Unexpected response %08h at %0t ns with nothing outstanding", rsp_data, $time);
        end
        if (exp_q.size() != 0 && !set_match) begin
          compare_data("response data", rsp_data, exp_q.pop_front());
        end else if (exp_q.size() != 0) begin
          hits = exp_q.find_first_index(x) with (x === rsp_data);
          assert (hits.size() != 0) else begin
            errors++;
            $display("Fail at %0t ns: response %08h matches no outstanding request",
                     $time, rsp_data);
          end
          if (hits.size() != 0) exp_q.delete(hits[0]);
        end
      end
    end
  end

  // Cache target, answers in order after 0 to 5 cycles
  initial begin : cache_responder
    spm_pkg::data_t rsp_q [$];
    int             dly_q [$];
    logic           took;
    cache_req_ready = 1'b0;
    cache_rsp_valid = 1'b0;
    cache_rsp_data  = '0;
    forever begin
      @(negedge clk);
      if (cache_req_valid && cache_req_ready) begin
        rsp_q.push_back(cache_req_write ? '0 : cache_req_addr ^ CACHE_KEY);
        dly_q.push_back($urandom_range(5, 0));
      end
      took = cache_rsp_valid && cache_rsp_ready;
      @(posedge clk);
      #1;
      cache_req_ready = ($urandom_range(3, 0) != 0);
      if (took) begin
        cache_rsp_valid = 1'b0;
        void'(rsp_q.pop_front());
        void'(dly_q.pop_front());
      end
      if (!cache_rsp_valid && rsp_q.size() != 0) begin
        if (dly_q[0] == 0) begin
          cache_rsp_valid = 1'b1;
          cache_rsp_data  = rsp_q[0];
        end else begin
          dly_q[0]--;
        end
      end
    end
  end

  initial begin : rsp_ready_driver
    rsp_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      rsp_ready = backpressure ? ($urandom_range(1, 0) == 1) : 1'b1;
    end
  end

  initial begin : watchdog
    while (cycle < MAX_CYCLES) begin
      @(posedge clk);
      cycle++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin : main_seq
    spm_pkg::addr_t addrs [N_SPM];
    spm_pkg::addr_t a;
    int             c0;
    int             e0;
    int             r0;
    int             kind;
    int             total;
    req_valid = 1'b0;
    req_addr  = '0;
    req_write = 1'b0;
    req_wdata = '0;
    req_strb  = '0;
    void'($urandom(SEED));
    @(posedge arst_n);
    @(posedge clk);
    #1;

    // 1: fill every word so that partial strobes merge into known bytes
    c0 = checks;
    e0 = errors;
    for (int w = 0; w < `SPM_WORDS; w++) begin
      a = WIN_START + spm_pkg::addr_t'(w * NB);
      issue_req(a, 1'b1, a ^ FILL_KEY, '1);
    end
    for (int i = 0; i < N_SPM; i++) begin
      addrs[i] = WIN_START + spm_pkg::addr_t'($urandom_range(`SPM_WORDS - 1, 0) * NB);
      issue_req(addrs[i], 1'b1, $urandom, spm_pkg::strb_t'($urandom));
    end
    for (int i = 0; i < N_SPM; i++) begin
      issue_req(addrs[i], 1'b0, '0, '0);
    end
    wait_idle();
    report_test(1, "SPM write then read", c0, e0);

    // 2: one read into an empty pipeline
    c0 = checks;
    e0 = errors;
    issue_req(WIN_START + spm_pkg::addr_t'($urandom_range(`SPM_WORDS - 1, 0) * NB), 1'b0, '0, '0);
    wait_idle();
    compare_data("SPM read latency in cycles", spm_pkg::data_t'(rsp_cycle - hs_cycle), 32'd2);
    report_test(2, "SPM latency", c0, e0);

    // 3
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_CACHE; i++) begin
      issue_req(random_cache_addr(), 1'($urandom_range(1, 0)), $urandom,
                spm_pkg::strb_t'($urandom));
    end
    wait_idle();
    report_test(3, "cache routing", c0, e0);

    // 4: the window past the populated SPM
    c0 = checks;
    e0 = errors;
    r0 = rsp_count;
    for (int i = 0; i < N_ERR; i++) begin
      a = WIN_START + SPM_SIZE
          + spm_pkg::addr_t'($urandom_range(WIN_END - WIN_START - SPM_SIZE - 1, 0));
      issue_req(a, 1'($urandom_range(1, 0)), $urandom, '1);
    end
    repeat (10) @(posedge clk);
    #1;
    compare_data("responses after error requests", spm_pkg::data_t'(rsp_count - r0), '0);
    report_test(4, "error requests", c0, e0);

    // 5: interleaved targets with a stalling core response port
    c0 = checks;
    e0 = errors;
    r0 = rsp_count;
    set_match    = 1'b1;
    backpressure = 1'b1;
    for (int i = 0; i < N_MIX; i++) begin
      kind = $urandom_range(2, 0);
      if (kind == 2) begin
        a = random_cache_addr();
      end else begin
        a = WIN_START + spm_pkg::addr_t'($urandom_range(`SPM_WORDS - 1, 0) * NB);
      end
      issue_req(a, (kind == 0) || (kind == 2 && $urandom_range(1, 0) == 1), $urandom,
                spm_pkg::strb_t'($urandom));
    end
    backpressure = 1'b0;
    wait_idle();
    set_match = 1'b0;
    compare_data("responses in mixed traffic", spm_pkg::data_t'(rsp_count - r0),
                 spm_pkg::data_t'(N_MIX));
    report_test(5, "mixed traffic with back-pressure", c0, e0);

    total = errors + int'(u_spm_subsystem_top.u_asserts.failures);
    $display("Summary: %0d checks, %0d check errors, %0d assertion failures", checks, errors,
             u_spm_subsystem_top.u_asserts.failures);
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+src
src/spm_pkg.sv
src/mem_req_if.sv
src/spm_addr_mapper.sv
src/spm_bank.sv
src/spm_rsp_merge.sv
src/spm_subsystem_top.sv
tests/spm_tb_clock.sv
tests/spm_subsystem_asserts.sv
tests/spm_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: spm_subsystem

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/spm_pkg.sv
      - src/mem_req_if.sv
      - src/spm_addr_mapper.sv
      - src/spm_bank.sv
      - src/spm_rsp_merge.sv
      - src/spm_subsystem_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/spm_tb_clock.sv
      - tests/spm_subsystem_asserts.sv
      - tests/spm_subsystem_tb.sv
